// ==== verilog/line_mirror_pkg.sv ====
// Line mirror shared definitions
`default_nettype none

package line_mirror_pkg;

   // --------------------
   // Request word widths
   // --------------------

   // One cache line of payload
   localparam int DATA_W = 512;
   // Cache line address
   localparam int ADDR_W = 20;
   // Transaction id carried with each write
   localparam int TID_W = 16;
   // Multi-line length code
   localparam int LEN_W = 2;

   // --------------------
   // Line buffer geometry
   // --------------------

   // Two banks, one filling while the other drains
   localparam int NUM_BANKS = 2;
   // Words left in a bank when almost-full rises
   localparam int ALMFULL_MARGIN = 8;
   // 32-bit pixel pairs per data word
   localparam int PAIRS_PER_WORD = 16;

   // --------------------
   // YUV pixel pair
   // --------------------

   // Component byte slots in a pixel pair, top down
   localparam int PIX_Y1 = 3;
   localparam int PIX_V0 = 2;
   localparam int PIX_Y0 = 1;
   localparam int PIX_U0 = 0;

   // Same 32 bits seen as a raw word or as four 8-bit components
   typedef union packed {
      logic [31:0]      raw;
      logic [3:0][7:0]  comp;
   } pixel_pair_t;

endpackage : line_mirror_pkg

`default_nettype wire

// ==== verilog/line_bank_ctrl.sv ====
// Line bank control
`default_nettype none

module line_bank_ctrl #(
   parameter int  LINE_WORDS = 60,
   localparam int PTR_W = $clog2(line_mirror_pkg::NUM_BANKS * LINE_WORDS)
) (
   input  logic             Clk_400,
   input  logic             arst_n,
   input  logic             in_valid,
   input  logic             out_sent,
   output logic             push,
   output logic             pop,
   output logic [PTR_W-1:0] wr_ptr,
   output logic [PTR_W-1:0] rd_ptr,
   output logic [PTR_W-1:0] hdr_ptr,
   output logic             in_ready,
   output logic             in_almost_full
);

   import line_mirror_pkg::*;

   // --------------------
   // Pointer constants
   // --------------------

   localparam int TOT_WORDS = NUM_BANKS * LINE_WORDS;
   localparam int STOCK_W   = $clog2(NUM_BANKS + 1);

   // Bank boundaries
   localparam logic [PTR_W-1:0] LO_LAST  = PTR_W'(LINE_WORDS - 1);
   localparam logic [PTR_W-1:0] HI_FIRST = PTR_W'(LINE_WORDS);
   localparam logic [PTR_W-1:0] HI_LAST  = PTR_W'(TOT_WORDS - 1);
   // Almost-full trip points, one per bank
   localparam logic [PTR_W-1:0] ALM_LO   = PTR_W'(LINE_WORDS - ALMFULL_MARGIN);
   localparam logic [PTR_W-1:0] ALM_HI   = PTR_W'(TOT_WORDS - ALMFULL_MARGIN);

   logic               wr_last;
   logic               rd_last;
   logic               line_done;
   logic               line_read;
   logic               line_done_q;
   logic [STOCK_W-1:0] stock_q;
   logic               stock_empty;
   logic               full_q;
   logic               full_set;
   logic               almfull_set;

   // --------------------
   // Handshake decode
   // --------------------

   // Accept only while a bank is free to fill
   assign push = in_valid & ~full_q;
   // Read only a completed line
   assign pop  = out_sent & ~stock_empty;

   assign in_ready = ~full_q;

   // Last word of a bank on either side
   assign wr_last = (wr_ptr == LO_LAST) || (wr_ptr == HI_LAST);
   assign rd_last = (rd_ptr == '0) || (rd_ptr == HI_FIRST);

   assign line_done = push & wr_last;
   assign line_read = pop & rd_last;

   assign stock_empty = (stock_q == '0);

   // Second line closes while the first is still held
   assign full_set = (stock_q == STOCK_W'(1)) & line_done & ~line_read;

   // Writer deep into the second bank with one line held
   assign almfull_set = (stock_q == STOCK_W'(1)) && ((wr_ptr == ALM_LO) || (wr_ptr == ALM_HI));

   // --------------------
   // Word counters
   // --------------------

   // Write side runs upward through both banks and wraps
   always_ff @(posedge Clk_400 or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
      end else if (push) begin
         if (wr_ptr == HI_LAST) begin
            wr_ptr <= '0;
         end else begin
            wr_ptr <= wr_ptr + PTR_W'(1);
         end
      end
   end

   // Read side walks each bank top to bottom
   // From 0 it jumps to the top of the upper bank
   always_ff @(posedge Clk_400 or negedge arst_n) begin
      if (!arst_n) begin
         rd_ptr <= LO_LAST;
      end else if (pop) begin
         if (rd_ptr == '0) begin
            rd_ptr <= HI_LAST;
         end else begin
            rd_ptr <= rd_ptr - PTR_W'(1);
         end
      end
   end

   // Header keeps forward order inside the bank being read
   always_comb begin
      if (rd_ptr < HI_FIRST) begin
         hdr_ptr = LO_LAST - rd_ptr;
      end else begin
         hdr_ptr = HI_FIRST + (HI_LAST - rd_ptr);
      end
   end

   // --------------------
   // Line stock
   // --------------------

   // Completion pulse one edge behind the last write
   always_ff @(posedge Clk_400 or negedge arst_n) begin
      if (!arst_n) begin
         line_done_q <= 1'b0;
      end else begin
         line_done_q <= line_done;
      end
   end

   // Count of completed lines not yet read out
   always_ff @(posedge Clk_400 or negedge arst_n) begin
      if (!arst_n) begin
         stock_q <= '0;
      end else if (line_done_q && !line_read) begin
         stock_q <= stock_q + STOCK_W'(1);
      end else if (!line_done_q && line_read) begin
         stock_q <= stock_q - STOCK_W'(1);
      end
   end

   // in_ready drops when both banks are committed
   always_ff @(posedge Clk_400 or negedge arst_n) begin
      if (!arst_n) begin
         full_q <= 1'b0;
      end else if (line_read) begin
         full_q <= 1'b0;
      end else if (full_set) begin
         full_q <= 1'b1;
      end
   end

   // Early warning for the source until a line drains
   always_ff @(posedge Clk_400 or negedge arst_n) begin
      if (!arst_n) begin
         in_almost_full <= 1'b0;
      end else if (line_read) begin
         in_almost_full <= 1'b0;
      end else if (almfull_set) begin
         in_almost_full <= 1'b1;
      end
   end

   // --------------------
   // Checks
   // --------------------

   // Never more lines held than banks
   a_stock_max : assert property (@(posedge Clk_400) disable iff (!arst_n)
      stock_q <= STOCK_W'(NUM_BANKS));

   // Nothing held means the reader waits at the top of a bank
   a_pop_stock : assert property (@(posedge Clk_400) disable iff (!arst_n)
      stock_empty |-> ((rd_ptr == LO_LAST) || (rd_ptr == HI_LAST)));

   // With a line held, writer and reader sit in different banks
   a_no_overwrite : assert property (@(posedge Clk_400) disable iff (!arst_n)
      (push && !stock_empty) |-> ((wr_ptr >= HI_FIRST) != (rd_ptr >= HI_FIRST)));

endmodule : line_bank_ctrl

`default_nettype wire

// ==== verilog/line_store.sv ====
// Line word and header store
`default_nettype none

module line_store #(
   parameter int  LINE_WORDS = 60,
   localparam int PTR_W = $clog2(line_mirror_pkg::NUM_BANKS * LINE_WORDS)
) (
   input  logic                               Clk_400,
   input  logic                               push,
   input  logic [PTR_W-1:0]                   wr_ptr,
   input  logic [PTR_W-1:0]                   rd_ptr,
   input  logic [PTR_W-1:0]                   hdr_ptr,
   input  logic [line_mirror_pkg::ADDR_W-1:0] in_addr,
   input  logic [line_mirror_pkg::TID_W-1:0]  in_tid,
   input  logic                               in_fence,
   input  logic [line_mirror_pkg::LEN_W-1:0]  in_len,
   input  logic                               in_sop,
   input  logic [line_mirror_pkg::DATA_W-1:0] in_data,
   output logic [line_mirror_pkg::ADDR_W-1:0] out_addr,
   output logic [line_mirror_pkg::TID_W-1:0]  out_tid,
   output logic                               out_fence,
   output logic [line_mirror_pkg::LEN_W-1:0]  out_len,
   output logic                               out_sop,
   output logic [line_mirror_pkg::DATA_W-1:0] out_data
);

   import line_mirror_pkg::*;

   localparam int TOT_WORDS = NUM_BANKS * LINE_WORDS;
   // Header fields packed above the data word
   localparam int HDR_W     = ADDR_W + TID_W + 1 + LEN_W + 1;
   localparam int ENTRY_W   = HDR_W + DATA_W;
   localparam int PAIR_W    = $bits(pixel_pair_t);

   // Both banks in one array, lower bank first
   logic [ENTRY_W-1:0] mem [TOT_WORDS];
   logic [DATA_W-1:0]  rd_word;
   logic [HDR_W-1:0]   hdr_word;

   // --------------------
   // Write and read
   // --------------------

   always_ff @(posedge Clk_400) begin
      if (push) begin
         mem[wr_ptr] <= {in_addr, in_tid, in_fence, in_len, in_sop, in_data};
      end
   end

   // Data leaves reversed, headers in order
   assign rd_word  = mem[rd_ptr][DATA_W-1:0];
   assign hdr_word = mem[hdr_ptr][ENTRY_W-1:DATA_W];

   assign {out_addr, out_tid, out_fence, out_len, out_sop} = hdr_word;

   // --------------------
   // Pixel byte reorder
   // --------------------

   for (genvar g = 0; g < PAIRS_PER_WORD; g++) begin : g_pair
      pixel_pair_t in_pair;
      pixel_pair_t out_pair;

      assign in_pair.raw = rd_word[g*PAIR_W +: PAIR_W];

      // Incoming bytes numbered 3..0, outgoing slots named by component
      always_comb begin
         out_pair.comp[PIX_Y1] = in_pair.comp[1];
         out_pair.comp[PIX_V0] = in_pair.comp[2];
         out_pair.comp[PIX_Y0] = in_pair.comp[3];
         out_pair.comp[PIX_U0] = in_pair.comp[0];
      end

      assign out_data[g*PAIR_W +: PAIR_W] = out_pair.raw;
   end

   // --------------------
   // Checks
   // --------------------

   // Control never steers a write outside the array
   a_wr_range : assert property (@(posedge Clk_400)
      push |-> (int'(wr_ptr) < TOT_WORDS));

   // Read and header indices stay inside the array
   a_rd_range : assert property (@(posedge Clk_400)
      (int'(rd_ptr) < TOT_WORDS) && (int'(hdr_ptr) < TOT_WORDS));

endmodule : line_store

`default_nettype wire

// ==== verilog/line_mirror.sv ====
// Line mirror reorder buffer
`default_nettype none

module line_mirror #(
   parameter int  LINE_WORDS = 60,
   localparam int PTR_W = $clog2(line_mirror_pkg::NUM_BANKS * LINE_WORDS)
) (
   input  logic                               Clk_400,
   input  logic                               arst_n,
   // Write requests from the source
   input  logic                               in_valid,
   input  logic [line_mirror_pkg::ADDR_W-1:0] in_addr,
   input  logic [line_mirror_pkg::TID_W-1:0]  in_tid,
   input  logic                               in_fence,
   input  logic [line_mirror_pkg::LEN_W-1:0]  in_len,
   input  logic                               in_sop,
   input  logic [line_mirror_pkg::DATA_W-1:0] in_data,
   output logic                               in_ready,
   output logic                               in_almost_full,
   // Mirrored words toward the sink
   input  logic                               out_sent,
   output logic                               out_valid,
   output logic [line_mirror_pkg::ADDR_W-1:0] out_addr,
   output logic [line_mirror_pkg::TID_W-1:0]  out_tid,
   output logic                               out_fence,
   output logic [line_mirror_pkg::LEN_W-1:0]  out_len,
   output logic                               out_sop,
   output logic [line_mirror_pkg::DATA_W-1:0] out_data
);

   logic             push;
   logic             pop;
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] hdr_ptr;

   // A word leaves in every cycle the control pops
   assign out_valid = pop;

   // --------------------
   // Counters and flags
   // --------------------

   line_bank_ctrl #(
      .LINE_WORDS (LINE_WORDS)
   ) u_ctrl (
      .Clk_400        (Clk_400),
      .arst_n         (arst_n),
      .in_valid       (in_valid),
      .out_sent       (out_sent),
      .push           (push),
      .pop            (pop),
      .wr_ptr         (wr_ptr),
      .rd_ptr         (rd_ptr),
      .hdr_ptr        (hdr_ptr),
      .in_ready       (in_ready),
      .in_almost_full (in_almost_full)
   );

   // --------------------
   // Two-bank storage
   // --------------------

   line_store #(
      .LINE_WORDS (LINE_WORDS)
   ) u_store (
      .Clk_400   (Clk_400),
      .push      (push),
      .wr_ptr    (wr_ptr),
      .rd_ptr    (rd_ptr),
      .hdr_ptr   (hdr_ptr),
      .in_addr   (in_addr),
      .in_tid    (in_tid),
      .in_fence  (in_fence),
      .in_len    (in_len),
      .in_sop    (in_sop),
      .in_data   (in_data),
      .out_addr  (out_addr),
      .out_tid   (out_tid),
      .out_fence (out_fence),
      .out_len   (out_len),
      .out_sop   (out_sop),
      .out_data  (out_data)
   );

endmodule : line_mirror

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// Testbench clock generator
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD = 20
) (
   output logic clk
);

   // Free running, first rising edge half a period in
   initial begin
      clk = 1'b0;
   end

   always begin
      #(PERIOD / 2) clk = ~clk;
   end

endmodule : tb_clk_gen

`default_nettype wire

// ==== verif/tb_line_mirror.sv ====
// Line mirror testbench
`default_nettype none

module tb_line_mirror;

   import line_mirror_pkg::*;

   localparam int LINE_WORDS   = 60;
   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 16;
   localparam int RANDOM_LINES = 6;
   localparam int HDR_W        = ADDR_W + TID_W + 1 + LEN_W + 1;
   // Random phase, one partial-then-full line, two lines of back-pressure
   localparam int TOTAL_WORDS  = (RANDOM_LINES + 1 + 2) * LINE_WORDS;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + 10 * TOTAL_WORDS + 500;

   logic              Clk_400;
   logic              arst_n;
   logic              in_valid;
   logic [ADDR_W-1:0] in_addr;
   logic [TID_W-1:0]  in_tid;
   logic              in_fence;
   logic [LEN_W-1:0]  in_len;
   logic              in_sop;
   logic [DATA_W-1:0] in_data;
   logic              in_ready;
   logic              in_almost_full;
   logic              out_sent;
   logic              out_valid;
   logic [ADDR_W-1:0] out_addr;
   logic [TID_W-1:0]  out_tid;
   logic              out_fence;
   logic [LEN_W-1:0]  out_len;
   logic              out_sop;
   logic [DATA_W-1:0] out_data;

   int seed = 32'h5fd6_ff80;
   int mismatch_count = 0;
   int fail_count = 0;
   // Accepted words in arrival order for the model
   logic [DATA_W-1:0] data_q[$];
   logic [HDR_W-1:0]  hdr_q[$];
   int acc_total = 0;
   int out_total = 0;
   int out_word = 0;
   int lines_out = 0;

   tb_clk_gen #(.PERIOD(CLK_PERIOD)) u_clk_gen (.clk(Clk_400));

   line_mirror #(.LINE_WORDS(LINE_WORDS)) dut (
      .Clk_400(Clk_400), .arst_n(arst_n),
      .in_valid(in_valid), .in_addr(in_addr), .in_tid(in_tid), .in_fence(in_fence),
      .in_len(in_len), .in_sop(in_sop), .in_data(in_data),
      .in_ready(in_ready), .in_almost_full(in_almost_full),
      .out_sent(out_sent), .out_valid(out_valid), .out_addr(out_addr), .out_tid(out_tid),
      .out_fence(out_fence), .out_len(out_len), .out_sop(out_sop), .out_data(out_data)
   );

   // --------------------
   // Helpers
   // --------------------

   function automatic logic rand_bit();
      logic [31:0] r;
      r = $random(seed);
      return r[0];
   endfunction

   function automatic logic [DATA_W-1:0] rand_word();
      logic [DATA_W-1:0] w;
      for (int i = 0; i < PAIRS_PER_WORD; i++) begin
         w[i*32 +: 32] = $random(seed);
      end
      return w;
   endfunction

   // Each pixel pair leaves as bytes 1, 2, 3, 0 from the top
   function automatic logic [DATA_W-1:0] mirror_pixels(input logic [DATA_W-1:0] w);
      logic [DATA_W-1:0] m;
      logic [31:0]       p;
      for (int i = 0; i < PAIRS_PER_WORD; i++) begin
         p = w[i*32 +: 32];
         m[i*32 +: 32] = {p[15:8], p[23:16], p[31:24], p[7:0]};
      end
      return m;
   endfunction

   task automatic compare_value(input string name, input logic [DATA_W-1:0] got,
                                input logic [DATA_W-1:0] exp);
      assert (got === exp) else begin
         mismatch_count++;
         $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic expect_true(input logic cond, input string what);
      assert (cond) else begin
         fail_count++;
         $display("At %0t %s", $time, what);
      end
   endtask

   // Score output word j of the oldest line with data reversed and header forward
   task automatic score_output();
      logic [ADDR_W-1:0] e_addr;
      logic [TID_W-1:0]  e_tid;
      logic              e_fence;
      logic [LEN_W-1:0]  e_len;
      logic              e_sop;
      expect_true(data_q.size() >= LINE_WORDS, "an output word appeared with no complete line");
      if (data_q.size() >= LINE_WORDS) begin
         {e_addr, e_tid, e_fence, e_len, e_sop} = hdr_q[out_word];
         compare_value("out_data", out_data,
                       mirror_pixels(data_q[LINE_WORDS - 1 - out_word]));
         compare_value("out_addr", DATA_W'(out_addr), DATA_W'(e_addr));
         compare_value("out_tid", DATA_W'(out_tid), DATA_W'(e_tid));
         compare_value("out_fence", DATA_W'(out_fence), DATA_W'(e_fence));
         compare_value("out_len", DATA_W'(out_len), DATA_W'(e_len));
         compare_value("out_sop", DATA_W'(out_sop), DATA_W'(e_sop));
      end
      out_word++;
      out_total++;
      // Retire a fully read line from the model
      if (out_word == LINE_WORDS) begin
         out_word = 0;
         lines_out++;
         while (data_q.size() > 0 && out_word < LINE_WORDS) begin
            data_q.delete(0);
            hdr_q.delete(0);
            out_word++;
         end
         out_word = 0;
      end
   endtask

   // Drive on the rising edge and sample at the falling edge
   task automatic step_cycle(input logic nv, input logic ns);
      logic [DATA_W-1:0] d;
      logic [31:0]       r;
      logic [31:0]       a;
      d = rand_word();
      r = $random(seed);
      a = $random(seed);
      @(posedge Clk_400);
      in_valid <= nv;
      out_sent <= ns;
      in_data  <= d;
      in_addr  <= a[ADDR_W-1:0];
      in_tid   <= r[TID_W-1:0];
      in_fence <= r[16];
      in_len   <= r[18:17];
      in_sop   <= r[19];
      @(negedge Clk_400);
      if (out_valid) begin
         score_output();
      end
      if (in_valid && in_ready) begin
         data_q.push_back(in_data);
         hdr_q.push_back({in_addr, in_tid, in_fence, in_len, in_sop});
         acc_total++;
      end
   endtask

   // --------------------
   // Test sequence
   // --------------------

   initial begin : main
      int   base;
      int   lines_base;
      int   wait_cycles;
      logic alm_seen;
      arst_n   = 1'b0;
      in_valid = 1'b0;
      in_addr  = '0;
      in_tid   = '0;
      in_fence = 1'b0;
      in_len   = '0;
      in_sop   = 1'b0;
      in_data  = '0;
      out_sent = 1'b0;
      repeat (RESET_CYCLES) @(posedge Clk_400);
      arst_n <= 1'b1;
      @(negedge Clk_400);
      compare_value("out_valid", DATA_W'(out_valid), DATA_W'(1'b0));
      compare_value("in_almost_full", DATA_W'(in_almost_full), DATA_W'(1'b0));
      compare_value("in_ready", DATA_W'(in_ready), DATA_W'(1'b1));

      // Random traffic on both sides, then drain
      base = acc_total + RANDOM_LINES * LINE_WORDS;
      while (acc_total < base) begin
         step_cycle(rand_bit(), rand_bit());
      end
      while (out_total < acc_total) begin
         step_cycle(1'b0, rand_bit());
      end

      // Partial line must stay inside even with the sink ready
      base = acc_total;
      while (acc_total < base + LINE_WORDS - 1) begin
         step_cycle(1'b1, 1'b1);
         compare_value("out_valid", DATA_W'(out_valid), DATA_W'(1'b0));
      end
      repeat (4) begin
         step_cycle(1'b0, 1'b1);
         compare_value("out_valid", DATA_W'(out_valid), DATA_W'(1'b0));
      end
      step_cycle(1'b1, 1'b1);
      wait_cycles = 0;
      while (!out_valid && wait_cycles < 2) begin
         step_cycle(1'b0, 1'b1);
         wait_cycles++;
      end
      expect_true(out_valid, "out_valid did not rise within two cycles of the last word");
      while (out_total < acc_total) begin
         step_cycle(1'b0, 1'b1);
      end

      // Fill with the sink stalled until in_ready falls
      base = acc_total;
      alm_seen = 1'b0;
      do begin
         step_cycle(1'b1, 1'b0);
         if (in_ready && in_almost_full) begin
            alm_seen = 1'b1;
         end
      end while (in_ready);
      assert (acc_total - base == 2 * LINE_WORDS) else begin
         fail_count++;
         $display("At %0t %0d words were accepted before in_ready fell, expected %0d",
                  $time, acc_total - base, 2 * LINE_WORDS);
      end
      expect_true(alm_seen, "in_almost_full was not high before in_ready fell");
      base = acc_total;
      repeat (4) begin
         step_cycle(1'b1, 1'b0);
      end
      expect_true(acc_total == base, "in_ready rose again while the sink was stalled");

      // Flags recover one line after the sink is released
      lines_base = lines_out;
      while (lines_out == lines_base) begin
         step_cycle(1'b0, 1'b1);
         if (lines_out == lines_base) begin
            compare_value("in_ready", DATA_W'(in_ready), DATA_W'(1'b0));
            compare_value("in_almost_full", DATA_W'(in_almost_full), DATA_W'(1'b1));
         end
      end
      step_cycle(1'b0, 1'b1);
      compare_value("in_ready", DATA_W'(in_ready), DATA_W'(1'b1));
      compare_value("in_almost_full", DATA_W'(in_almost_full), DATA_W'(1'b0));
      // Everything accepted must come back out within a bounded drain
      wait_cycles = 0;
      while (out_total < acc_total && wait_cycles < 4 * LINE_WORDS) begin
         step_cycle(1'b0, 1'b1);
         wait_cycles++;
      end
      expect_true(out_total == acc_total, "accepted words were never sent out");

      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
      if (mismatch_count == 0 && fail_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Bound on run time from the total word count
   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired at %0t, the test did not complete", $time);
      $display("TEST FAILED");
      $finish;
   end

endmodule : tb_line_mirror

`default_nettype wire

// ==== list.f ====
verilog/line_mirror_pkg.sv
verilog/line_bank_ctrl.sv
verilog/line_store.sv
verilog/line_mirror.sv
verif/tb_clk_gen.sv
verif/tb_line_mirror.sv

// ==== Makefile ====
# Verilator build and run for the line mirror testbench

VERILATOR ?= verilator
TOP       ?= tb_line_mirror
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

# Sources taken from the file list, option lines skipped
SRCS    := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
	   echo "Simulation reported a failure, see $(LOG)"; \
	   exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
	   echo "Simulation ended without a result line, see $(LOG)"; \
	   exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
